//--- verilog/saturn_isa_pkg.sv
// instruction set definitions for the 0x group front end
// shared by fetch, decoder, exec and the top level
package saturn_isa_pkg;

  // one instruction step moves one nibble
  localparam int nib_w = 4;

  // pc and instruction address width
  localparam int addr_w = 20;

  // return stack, oldest entry lost on overflow
  localparam int rstk_depth = 8;
  // level counts 0 .. rstk_depth inclusive
  localparam int rstk_lvl_w = $clog2(rstk_depth + 1);

  // decoded operations of the 0x group
  // op_none means no instruction this cycle
  typedef enum logic [3:0] {
    op_none,
    op_rtn_sxm,
    op_rtn,
    op_rtn_sc,
    op_rtn_cc,
    op_set_hex,
    op_set_dec,
    op_rstk_gets_c,
    op_c_gets_rstk
  } ins_op_e;

  // field table selector for the field nibble
  typedef enum logic [1:0] {
    ft_a,
    ft_b,
    ft_f,
    ft_value
  } field_table_e;

  // decoder position inside an instruction
  typedef enum logic [1:0] {
    st_first,
    st_block_0x,
    st_field_nibble,
    st_block_0ef
  } dec_state_e;

endpackage

//--- verilog/saturn_bus_pkg.sv
// program memory and bus definitions
// used by the memory, the arbiter and the top level
package saturn_bus_pkg;

  // nibble count of the program memory
  localparam int mem_depth = 256;

  // low pc bits address the memory, so the pc wraps inside it
  localparam int mem_aw = $clog2(mem_depth);

  // who owns the memory port
  // loader always wins over fetch
  typedef enum logic {
    req_loader,
    req_fetch
  } bus_req_e;

endpackage

//--- verilog/saturn_nibble_mem.sv
// single-port nibble program memory, read data one cycle after the request
`timescale 1ns/1ps

module saturn_nibble_mem (
  input  logic                              i_clk,
  input  logic                              i_en,
  input  logic                              i_we,
  input  logic [saturn_bus_pkg::mem_aw-1:0] i_addr,
  input  logic [saturn_isa_pkg::nib_w-1:0]  i_wdata,
  output logic [saturn_isa_pkg::nib_w-1:0]  o_rdata
);
  import saturn_bus_pkg::*;
  import saturn_isa_pkg::*;

  // storage array, contents come from the loader
  logic [nib_w-1:0] mem [mem_depth];

  // write port
  always_ff @(posedge i_clk) begin
    if (i_en && i_we) begin
      mem[i_addr] <= i_wdata;
    end
  end

  // registered read
  // old data is kept while idle or writing
  always_ff @(posedge i_clk) begin
    if (i_en && !i_we) begin
      o_rdata <= mem[i_addr];
    end
  end

endmodule

//--- verilog/saturn_bus_arbiter.sv
// fixed-priority arbiter for the program memory port
// loader writes first, fetch reads only on a free cycle
`timescale 1ns/1ps

module saturn_bus_arbiter (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_load_we,
  input  logic [saturn_bus_pkg::mem_aw-1:0] i_load_addr,
  input  logic [saturn_isa_pkg::nib_w-1:0]  i_load_nibble,
  input  logic                              i_fetch_req,
  input  logic [saturn_bus_pkg::mem_aw-1:0] i_fetch_addr,
  output logic                              o_fetch_gnt,
  output logic                              o_mem_en,
  output logic                              o_mem_we,
  output logic [saturn_bus_pkg::mem_aw-1:0] o_mem_addr,
  output logic [saturn_isa_pkg::nib_w-1:0]  o_mem_wdata
);
  import saturn_bus_pkg::*;

  // owner of the last access, tags the read data
  bus_req_e last_owner;

  // port mux, loader first
  always_comb begin
    o_fetch_gnt = 1'b0;
    o_mem_en    = 1'b0;
    o_mem_we    = 1'b0;
    o_mem_addr  = i_fetch_addr;
    o_mem_wdata = i_load_nibble;
    if (i_load_we) begin
      // load strobe, fetch stalls this cycle
      o_mem_en   = 1'b1;
      o_mem_we   = 1'b1;
      o_mem_addr = i_load_addr;
    end else if (i_fetch_req) begin
      // read reaches the memory, so grant it
      o_mem_en    = 1'b1;
      o_fetch_gnt = 1'b1;
    end
  end

  // owner tracking
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      last_owner <= req_fetch;
    end else if (o_mem_en) begin
      last_owner <= i_load_we ? req_loader : req_fetch;
    end
  end

endmodule

//--- verilog/saturn_fetch.sv
// instruction fetch, one nibble per granted read
// presents each returned nibble with its address to the decoder
`timescale 1ns/1ps

module saturn_fetch (
  input  logic                              i_clk,
  input  logic                              i_reset,
  input  logic                              i_run,
  input  logic                              i_halt,
  input  logic                              i_gnt,
  input  logic [saturn_isa_pkg::nib_w-1:0]  i_rdata,
  input  logic                              i_redirect,
  input  logic [saturn_isa_pkg::addr_w-1:0] i_redirect_pc,
  output logic                              o_req,
  output logic [saturn_isa_pkg::addr_w-1:0] o_addr,
  output logic                              o_nib_valid,
  output logic [saturn_isa_pkg::nib_w-1:0]  o_nib,
  output logic [saturn_isa_pkg::addr_w-1:0] o_nib_pc
);
  import saturn_isa_pkg::*;

  logic [addr_w-1:0] pc;
  // address of the read in flight
  logic [addr_w-1:0] rd_pc;
  logic              in_flight;

  // request as a level
  // no read on a redirect cycle, the pc is still the old one
  assign o_req  = i_run & ~i_halt & ~i_redirect;
  assign o_addr = pc;

  // returned nibble, dropped when a return redirects
  assign o_nib_valid = in_flight & ~i_redirect;
  assign o_nib       = i_rdata;
  assign o_nib_pc    = rd_pc;

  // pc and in-flight flag
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc        <= '0;
      in_flight <= 1'b0;
    end else if (i_redirect) begin
      // jump, cancel anything pending
      pc        <= i_redirect_pc;
      in_flight <= 1'b0;
    end else begin
      // a load stall leaves the pc where it is
      in_flight <= i_gnt;
      if (i_gnt) begin
        pc <= pc + addr_w'(1);
      end
    end
  end

  // remember where the read went
  always_ff @(posedge i_clk) begin
    if (i_gnt) begin
      rd_pc <= pc;
    end
  end

endmodule

//--- verilog/saturn_decoder.sv
// nibble-serial decoder for the 0x group and the 0E prefix
// emits one pulse per instruction, a sticky error on anything unhandled
`timescale 1ns/1ps

module saturn_decoder (
  input  logic                                 i_clk,
  input  logic                                 i_reset,
  input  logic                                 i_nib_valid,
  input  logic [saturn_isa_pkg::nib_w-1:0]     i_nib,
  input  logic [saturn_isa_pkg::addr_w-1:0]    i_nib_pc,
  output logic                                 o_ins_decoded,
  output saturn_isa_pkg::ins_op_e              o_ins_op,
  output logic [saturn_isa_pkg::addr_w-1:0]    o_ins_addr,
  output saturn_isa_pkg::field_table_e         o_fields_table,
  output logic                                 o_dec_error
);
  import saturn_isa_pkg::*;

  dec_state_e state;
  // only field A of table f is implemented
  logic       field_a;

  assign field_a = (o_fields_table == ft_f) && (i_nib == 4'hf);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state          <= st_first;
      o_ins_decoded  <= 1'b0;
      o_ins_op       <= op_none;
      o_fields_table <= ft_value;
      o_dec_error    <= 1'b0;
    end else begin
      // pulse lasts one cycle
      o_ins_decoded <= 1'b0;
      // strobes are ignored once the error is up
      if (i_nib_valid && !o_dec_error) begin
        case (state)
          st_first: begin
            // only group 0 exists here
            if (i_nib == 4'h0) begin
              o_fields_table <= ft_value;
              state          <= st_block_0x;
            end else begin
              o_dec_error <= 1'b1;
            end
          end
          st_block_0x: begin
            state <= st_first;
            case (i_nib)
              4'h0: o_ins_op <= op_rtn_sxm;
              4'h1: o_ins_op <= op_rtn;
              4'h2: o_ins_op <= op_rtn_sc;
              4'h3: o_ins_op <= op_rtn_cc;
              4'h4: o_ins_op <= op_set_hex;
              4'h5: o_ins_op <= op_set_dec;
              4'h6: o_ins_op <= op_rstk_gets_c;
              4'h7: o_ins_op <= op_c_gets_rstk;
              4'he: begin
                // 0E prefix, a field nibble follows
                o_fields_table <= ft_f;
                state          <= st_field_nibble;
              end
              default: o_dec_error <= 1'b1;
            endcase
            if (i_nib <= 4'h7) begin
              o_ins_decoded <= 1'b1;
            end
          end
          st_field_nibble: begin
            if (field_a) begin
              state <= st_block_0ef;
            end else begin
              o_dec_error <= 1'b1;
              state       <= st_first;
            end
          end
          default: begin
            // 0Ef operation nibble, none handled yet
            o_dec_error <= 1'b1;
            state       <= st_first;
          end
        endcase
      end
    end
  end

  // start address of the instruction
  always_ff @(posedge i_clk) begin
    if (i_nib_valid && !o_dec_error && state == st_first) begin
      o_ins_addr <= i_nib_pc;
    end
  end

endmodule

//--- verilog/saturn_exec.sv
// execute unit for the 0x group
// return stack, carry, mode, xm and the C A field, plus return redirect
`timescale 1ns/1ps

module saturn_exec (
  input  logic                                  i_clk,
  input  logic                                  i_reset,
  input  logic                                  i_ins_decoded,
  input  saturn_isa_pkg::ins_op_e               i_ins_op,
  input  logic                                  i_dec_error,
  input  logic                                  i_c_load,
  input  logic [saturn_isa_pkg::addr_w-1:0]     i_c_value,
  output logic                                  o_redirect,
  output logic [saturn_isa_pkg::addr_w-1:0]     o_redirect_pc,
  output logic                                  o_halt,
  output logic                                  o_carry,
  output logic                                  o_mode_dec,
  output logic                                  o_xm,
  output logic [saturn_isa_pkg::addr_w-1:0]     o_c_a,
  output logic [saturn_isa_pkg::rstk_lvl_w-1:0] o_rstk_level
);
  import saturn_isa_pkg::*;

  // entry 0 is the top
  logic [addr_w-1:0] rstk [rstk_depth];
  logic [addr_w-1:0] top;
  logic              is_rtn;
  logic              do_push;
  logic              do_pop;

  // empty stack pops as 0
  assign top = (o_rstk_level == '0) ? '0 : rstk[0];

  assign is_rtn  = i_ins_op inside {op_rtn_sxm, op_rtn, op_rtn_sc, op_rtn_cc};
  assign do_pop  = i_ins_decoded & (is_rtn | (i_ins_op == op_c_gets_rstk));
  assign do_push = i_ins_decoded & (i_ins_op == op_rstk_gets_c);

  // return jumps in the decode cycle itself
  assign o_redirect    = i_ins_decoded & is_rtn;
  assign o_redirect_pc = top;
  assign o_halt        = i_dec_error;

  // stack shifts, the oldest entry falls off the bottom
  always_ff @(posedge i_clk) begin
    if (do_push) begin
      for (int i = rstk_depth - 1; i > 0; i--) begin
        rstk[i] <= rstk[i-1];
      end
      rstk[0] <= o_c_a;
    end else if (do_pop) begin
      for (int i = 0; i < rstk_depth - 1; i++) begin
        rstk[i] <= rstk[i+1];
      end
    end
  end

  // level saturates at both ends
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_rstk_level <= '0;
    end else if (do_push && o_rstk_level != rstk_lvl_w'(rstk_depth)) begin
      o_rstk_level <= o_rstk_level + 1'b1;
    end else if (do_pop && o_rstk_level != '0) begin
      o_rstk_level <= o_rstk_level - 1'b1;
    end
  end

  // flags and C A field
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_carry    <= 1'b0;
      o_mode_dec <= 1'b0;
      o_xm       <= 1'b0;
      o_c_a      <= '0;
    end else begin
      if (i_ins_decoded) begin
        case (i_ins_op)
          // xm is sticky
          op_rtn_sxm:     o_xm       <= 1'b1;
          op_rtn_sc:      o_carry    <= 1'b1;
          op_rtn_cc:      o_carry    <= 1'b0;
          op_set_hex:     o_mode_dec <= 1'b0;
          op_set_dec:     o_mode_dec <= 1'b1;
          op_c_gets_rstk: o_c_a      <= top;
          default:        ;
        endcase
      end
      // external write of C
      if (i_c_load) begin
        o_c_a <= i_c_value;
      end
    end
  end

endmodule

//--- verilog/saturn_core.sv
// front end top level: memory, arbiter, fetch, decoder and exec
// the loader writes the program, i_run starts fetching from address 0
`timescale 1ns/1ps

module saturn_core (
  input  logic                                  i_clk,
  input  logic                                  i_reset,
  input  logic                                  i_run,
  input  logic                                  i_load_we,
  input  logic [saturn_bus_pkg::mem_aw-1:0]     i_load_addr,
  input  logic [saturn_isa_pkg::nib_w-1:0]      i_load_nibble,
  input  logic                                  i_c_load,
  input  logic [saturn_isa_pkg::addr_w-1:0]     i_c_value,
  output logic                                  o_ins_decoded,
  output saturn_isa_pkg::ins_op_e               o_ins_op,
  output logic [saturn_isa_pkg::addr_w-1:0]     o_ins_addr,
  output logic                                  o_dec_error,
  output logic                                  o_carry,
  output logic                                  o_mode_dec,
  output logic                                  o_xm,
  output logic [saturn_isa_pkg::addr_w-1:0]     o_c_a,
  output logic [saturn_isa_pkg::rstk_lvl_w-1:0] o_rstk_level
);
  import saturn_isa_pkg::*;
  import saturn_bus_pkg::*;

  // memory port
  logic              mem_en;
  logic              mem_we;
  logic [mem_aw-1:0] mem_addr;
  logic [nib_w-1:0]  mem_wdata;
  logic [nib_w-1:0]  mem_rdata;

  // fetch side
  logic              fetch_req;
  logic              fetch_gnt;
  logic [addr_w-1:0] fetch_addr;
  logic              nib_valid;
  logic [nib_w-1:0]  nib;
  logic [addr_w-1:0] nib_pc;

  // decoder and exec
  logic              ins_decoded;
  ins_op_e           ins_op;
  logic [addr_w-1:0] ins_addr;
  field_table_e      fields_table;
  logic              dec_error;
  logic              redirect;
  logic [addr_w-1:0] redirect_pc;
  logic              halt;
  // C writes only while stopped
  logic              c_load_ok;

  assign c_load_ok = i_c_load & ~i_run;

  assign o_ins_decoded = ins_decoded;
  assign o_ins_op      = ins_op;
  assign o_ins_addr    = ins_addr;
  assign o_dec_error   = dec_error;

  saturn_nibble_mem u_mem (
    .i_clk   (i_clk),
    .i_en    (mem_en),
    .i_we    (mem_we),
    .i_addr  (mem_addr),
    .i_wdata (mem_wdata),
    .o_rdata (mem_rdata)
  );

  // pc low bits address the memory
  saturn_bus_arbiter u_arb (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_load_we     (i_load_we),
    .i_load_addr   (i_load_addr),
    .i_load_nibble (i_load_nibble),
    .i_fetch_req   (fetch_req),
    .i_fetch_addr  (fetch_addr[mem_aw-1:0]),
    .o_fetch_gnt   (fetch_gnt),
    .o_mem_en      (mem_en),
    .o_mem_we      (mem_we),
    .o_mem_addr    (mem_addr),
    .o_mem_wdata   (mem_wdata)
  );

  saturn_fetch u_fetch (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_run         (i_run),
    .i_halt        (halt),
    .i_gnt         (fetch_gnt),
    .i_rdata       (mem_rdata),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_req         (fetch_req),
    .o_addr        (fetch_addr),
    .o_nib_valid   (nib_valid),
    .o_nib         (nib),
    .o_nib_pc      (nib_pc)
  );

  saturn_decoder u_dec (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_nib_valid    (nib_valid),
    .i_nib          (nib),
    .i_nib_pc       (nib_pc),
    .o_ins_decoded  (ins_decoded),
    .o_ins_op       (ins_op),
    .o_ins_addr     (ins_addr),
    .o_fields_table (fields_table),
    .o_dec_error    (dec_error)
  );

  saturn_exec u_exec (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_ins_decoded (ins_decoded),
    .i_ins_op      (ins_op),
    .i_dec_error   (dec_error),
    .i_c_load      (c_load_ok),
    .i_c_value     (i_c_value),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc),
    .o_halt        (halt),
    .o_carry       (o_carry),
    .o_mode_dec    (o_mode_dec),
    .o_xm          (o_xm),
    .o_c_a         (o_c_a),
    .o_rstk_level  (o_rstk_level)
  );

endmodule

//--- tb/saturn_core_properties.sv
// concurrent checks on the memory arbiter and the decoder outputs
// bound into saturn_core by the testbench
`timescale 1ns/1ps

module saturn_core_properties (
  input logic                     i_clk,
  input logic                     i_reset,
  input logic                     i_nib_valid,
  input saturn_bus_pkg::bus_req_e i_last_owner,
  input logic                     i_ins_decoded,
  input logic                     i_dec_error
);
  import saturn_bus_pkg::*;

  // failed assertions so far
  int prop_failures = 0;

  // one pulse per instruction
  property ins_pulse_single;
    @(posedge i_clk) disable iff (i_reset)
      i_ins_decoded |=> !i_ins_decoded;
  endproperty

  // a nibble handed to the decoder comes from a fetch read, never a load cycle
  property fetch_owns_nibble;
    @(posedge i_clk) disable iff (i_reset)
      i_nib_valid |-> (i_last_owner == req_fetch);
  endproperty

  // only reset clears the error
  property error_sticky;
    @(posedge i_clk) (i_dec_error && !i_reset) |=> i_dec_error;
  endproperty

  ins_pulse_chk: assert property (ins_pulse_single) else begin
    prop_failures++;
    $error("decode pulse lasted longer than one cycle");
  end

  load_gnt_chk: assert property (fetch_owns_nibble) else begin
    prop_failures++;
    $error("nibble reached the decoder from a loader cycle");
  end

  error_hold_chk: assert property (error_sticky) else begin
    prop_failures++;
    $error("decoder error dropped without reset");
  end

endmodule

//--- tb/saturn_core_tb.sv
// testbench for the saturn front end, random 0x programs checked against a model
// loads each program, C values and idle writes, then compares every decoded instruction
`timescale 1ns/1ps

module saturn_core_tb;
  import saturn_isa_pkg::*;
  import saturn_bus_pkg::*;

  // instructions over all tests, sizes the watchdog
  localparam int total_ins       = 470;
  localparam int watchdog_cycles = total_ins * 40 + 2000;

  logic                  i_clk;
  logic                  i_reset;
  logic                  i_run;
  logic                  i_load_we;
  logic [mem_aw-1:0]     i_load_addr;
  logic [nib_w-1:0]      i_load_nibble;
  logic                  i_c_load;
  logic [addr_w-1:0]     i_c_value;
  logic                  o_ins_decoded;
  ins_op_e               o_ins_op;
  logic [addr_w-1:0]     o_ins_addr;
  logic                  o_dec_error;
  logic                  o_carry;
  logic                  o_mode_dec;
  logic                  o_xm;
  logic [addr_w-1:0]     o_c_a;
  logic [rstk_lvl_w-1:0] o_rstk_level;

  // reference model state
  logic [nib_w-1:0]  m_mem [mem_depth];
  logic [addr_w-1:0] m_stk [$];
  logic [addr_w-1:0] m_pc;
  logic [addr_w-1:0] m_c;
  logic              m_carry;
  logic              m_dec;
  logic              m_xm;
  // model reached an instruction outside the 0x group
  logic              m_err;

  // checker scratch
  ins_op_e           exp_op;
  logic [addr_w-1:0] next_pc;
  logic [nib_w-1:0]  op_nib;
  logic [mem_aw-1:0] ia;
  logic              state_due;
  logic [15:0]       lfsr;
  string             test_name;
  int                pulses;
  int                checks;
  int                errors;

  saturn_core DUT (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_run         (i_run),
    .i_load_we     (i_load_we),
    .i_load_addr   (i_load_addr),
    .i_load_nibble (i_load_nibble),
    .i_c_load      (i_c_load),
    .i_c_value     (i_c_value),
    .o_ins_decoded (o_ins_decoded),
    .o_ins_op      (o_ins_op),
    .o_ins_addr    (o_ins_addr),
    .o_dec_error   (o_dec_error),
    .o_carry       (o_carry),
    .o_mode_dec    (o_mode_dec),
    .o_xm          (o_xm),
    .o_c_a         (o_c_a),
    .o_rstk_level  (o_rstk_level)
  );

  bind saturn_core saturn_core_properties u_props (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_nib_valid   (nib_valid),
    .i_last_owner  (u_arb.last_owner),
    .i_ins_decoded (ins_decoded),
    .i_dec_error   (dec_error)
  );

  // 40 ns period
  initial i_clk = 1'b0;
  always #20 i_clk = ~i_clk;

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // low bits land on an instruction start inside the program
  function automatic logic [addr_w-1:0] rand_c(input int p_len);
    logic [6:0] ofs;
    ofs = 7'(2 * (rand_bits(6) % p_len));
    return {12'(rand_bits(12)), 1'b0, ofs};
  endfunction

  // empty stack pops as 0
  function automatic logic [addr_w-1:0] pop_model();
    if (m_stk.size() == 0) begin
      return '0;
    end
    return m_stk.pop_front();
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // inputs change 2 ns after the edge
  task automatic step();
    @(posedge i_clk);
    #2;
  endtask

  task automatic apply_reset();
    i_reset = 1'b1;
    i_run   = 1'b0;
    repeat (16) step();
    i_reset = 1'b0;
    m_stk.delete();
    m_pc      = '0;
    m_c       = '0;
    m_carry   = 1'b0;
    m_dec     = 1'b0;
    m_xm      = 1'b0;
    m_err     = 1'b0;
    state_due = 1'b0;
  endtask

  // one-cycle loader write, mirrored into the model
  task automatic load_nibble(input logic [mem_aw-1:0] a, input logic [nib_w-1:0] v);
    i_load_we     = 1'b1;
    i_load_addr   = a;
    i_load_nibble = v;
    m_mem[a]      = v;
    step();
    i_load_we = 1'b0;
  endtask

  // C write, only taken while stopped
  task automatic load_c(input logic [addr_w-1:0] v);
    i_c_load  = 1'b1;
    i_c_value = v;
    m_c       = v;
    step();
    i_c_load = 1'b0;
  endtask

  // mix 0 uniform, 1 starts with 12 pushes, 2 has no returns
  // term 0 ends in a bad first nibble, term 1 in a 0E sequence
  task automatic run_test(input string name, input int mix, input int term,
                          input int p_len, input int n_ins, input int pause_every);
    int               next_pause;
    logic [nib_w-1:0] op;
    logic [6:0]       la;
    logic [nib_w-1:0] lv;
    test_name = name;
    apply_reset();
    // two nibbles per instruction from address 0
    for (int i = 0; i < p_len; i++) begin
      if (mix == 2) begin
        op = 4'(4 + rand_bits(2));
      end else if (mix == 1 && i < 12) begin
        op = 4'h6;
      end else begin
        op = 4'(rand_bits(3));
      end
      load_nibble(mem_aw'(2 * i), 4'h0);
      load_nibble(mem_aw'(2 * i + 1), op);
    end
    if (term == 0) begin
      op = 4'(rand_bits(4));
      load_nibble(mem_aw'(2 * p_len), (op == 4'h0) ? 4'h9 : op);
    end else begin
      load_nibble(mem_aw'(2 * p_len), 4'h0);
      load_nibble(mem_aw'(2 * p_len + 1), 4'he);
      load_nibble(mem_aw'(2 * p_len + 2), 4'(rand_bits(4)));
      load_nibble(mem_aw'(2 * p_len + 3), 4'(rand_bits(4)));
    end
    load_c(rand_c(p_len));
    pulses     = 0;
    next_pause = pause_every;
    i_run      = 1'b1;
    // keep running until a predicted error has shown up
    while ((pulses < n_ins || m_err) && !o_dec_error) begin
      if (pulses >= next_pause) begin
        // stop and drain before writing a new C
        i_run = 1'b0;
        repeat (4) step();
        load_c(rand_c(p_len));
        i_run      = 1'b1;
        next_pause = next_pause + pause_every;
      end
      // idle writes land in the upper half and stall fetch
      if (rand_bits(2) == 0) begin
        la = 7'(rand_bits(7));
        lv = 4'(rand_bits(4));
        load_nibble({1'b1, la}, lv);
      end else begin
        step();
      end
    end
    i_run = 1'b0;
    repeat (8) step();
    check_value("dec_error", 32'(m_err), 32'(o_dec_error));
    if (mix == 2) begin
      check_value("error reached", 32'd1, 32'(o_dec_error));
    end
  endtask

  // model step on every decode pulse, state compared one cycle later
  always @(negedge i_clk) begin
    if (state_due) begin
      state_due = 1'b0;
      check_value("carry", 32'(m_carry), 32'(o_carry));
      check_value("mode_dec", 32'(m_dec), 32'(o_mode_dec));
      check_value("xm", 32'(m_xm), 32'(o_xm));
      check_value("c_a", 32'(m_c), 32'(o_c_a));
      check_value("rstk_level", m_stk.size(), 32'(o_rstk_level));
    end
    if (o_ins_decoded) begin
      pulses++;
      assert (!m_err) else begin
        errors++;
        $display("%s: instruction at %h decoded after the decoder should have stopped",
                 test_name, o_ins_addr);
      end
      ia      = m_pc[mem_aw-1:0];
      op_nib  = m_mem[ia + 1'b1];
      next_pc = m_pc + addr_w'(2);
      case (op_nib)
        4'h0: begin
          exp_op  = op_rtn_sxm;
          m_xm    = 1'b1;
          next_pc = pop_model();
        end
        4'h1: begin
          exp_op  = op_rtn;
          next_pc = pop_model();
        end
        4'h2: begin
          exp_op  = op_rtn_sc;
          m_carry = 1'b1;
          next_pc = pop_model();
        end
        4'h3: begin
          exp_op  = op_rtn_cc;
          m_carry = 1'b0;
          next_pc = pop_model();
        end
        4'h4: begin
          exp_op = op_set_hex;
          m_dec  = 1'b0;
        end
        4'h5: begin
          exp_op = op_set_dec;
          m_dec  = 1'b1;
        end
        4'h6: begin
          exp_op = op_rstk_gets_c;
          m_stk.push_front(m_c);
          // oldest entry falls off
          if (m_stk.size() > rstk_depth) begin
            m_stk.delete(rstk_depth);
          end
        end
        4'h7: begin
          exp_op = op_c_gets_rstk;
          m_c    = pop_model();
        end
        default: exp_op = op_none;
      endcase
      check_value("address", 32'(m_pc), 32'(o_ins_addr));
      check_value("op", 32'(exp_op), 32'(o_ins_op));
      m_pc      = next_pc;
      state_due = 1'b1;
      // next instruction outside the 0x group stops decoding
      ia = m_pc[mem_aw-1:0];
      if (m_mem[ia] != 4'h0 || m_mem[ia + 1'b1] > 4'h7) begin
        m_err = 1'b1;
      end
    end
  end

  // watchdog
  initial begin
    #(watchdog_cycles * 40);
    $display("watchdog expired before the last test ended, %0d errors so far", errors);
    $display("Test failures found");
    $finish;
  end

  initial begin
    lfsr          = 16'd21207;
    i_reset       = 1'b1;
    i_run         = 1'b0;
    i_load_we     = 1'b0;
    i_load_addr   = '0;
    i_load_nibble = '0;
    i_c_load      = 1'b0;
    i_c_value     = '0;
    checks        = 0;
    errors        = 0;
    pulses        = 0;
    state_due     = 1'b0;
    m_err         = 1'b0;
    test_name     = "init";
    run_test("random_mix_a", 0, 1, 40, 120, 16);
    run_test("push_overflow", 1, 0, 40, 80, 2);
    run_test("random_mix_b", 0, 0, 48, 150, 20);
    run_test("bad_first_nibble", 2, 0, 40, 60, 50);
    run_test("prefix_0e", 2, 1, 40, 60, 50);
    $display("checks: %0d, check errors: %0d, assertion errors: %0d",
             checks, errors, DUT.u_props.prop_failures);
    if (errors == 0 && DUT.u_props.prop_failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- build.f
verilog/saturn_isa_pkg.sv
verilog/saturn_bus_pkg.sv
verilog/saturn_nibble_mem.sv
verilog/saturn_bus_arbiter.sv
verilog/saturn_fetch.sv
verilog/saturn_decoder.sv
verilog/saturn_exec.sv
verilog/saturn_core.sv
tb/saturn_core_properties.sv
tb/saturn_core_tb.sv

//--- Bender.yml
package:
  name: saturn_core

sources:
  - verilog/saturn_isa_pkg.sv
  - verilog/saturn_bus_pkg.sv
  - verilog/saturn_nibble_mem.sv
  - verilog/saturn_bus_arbiter.sv
  - verilog/saturn_fetch.sv
  - verilog/saturn_decoder.sv
  - verilog/saturn_exec.sv
  - verilog/saturn_core.sv
  - target: simulation
    files:
      - tb/saturn_core_properties.sv
      - tb/saturn_core_tb.sv
